//--- dv/erx_core_tasks.svh
// ##################################################
// helpers
// ##################################################

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(input int nbits);
   logic [31:0] val;
   val = '0;
   for (int i = 0; i < nbits; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
   end
   return val;
endfunction

function automatic erx_pkt_t rand_pkt();
   erx_pkt_t p;
   p.addr.flat = rand_bits(32);
   p.data      = rand_bits(32);
   p.write     = 1'b1;
   return p;
endfunction

// ERX_CFG layout, msb first
function automatic logic [31:0] cfg_word(input logic en, input logic [1:0] mode,
      input logic [11:0] sel, input logic [11:0] pattern, input logic [1:0] timer);
   return {2'b00, timer, pattern, sel, mode, 1'b0, en};
endfunction

// expected address, bit by bit on the row/col field
function automatic logic [31:0] remapped(input logic [1:0] mode, input logic [11:0] sel,
      input logic [11:0] pattern, input logic [31:0] base, input logic [31:0] addr);
   logic [31:0] res;
   res = addr;
   if (mode == 2'b01) begin
      for (int b = 0; b < 12; b++) begin
         if (sel[b]) begin
            res[20+b] = pattern[b];
         end
      end
   end else if (mode == 2'b10) begin
      res = addr + base;  // mod 2^32
   end
   return res;
endfunction

task automatic start_test(input string name);
   cur_test    = name;
   test_errors = 0;
   tests_run++;
endtask

task automatic end_test();
   if (test_errors == 0) begin
      $display("test %s: ok", cur_test);
   end else begin
      $display("test %s: %0d error(s)", cur_test, test_errors);
   end
endtask

task automatic check(input string what, input logic [64:0] exp, input logic [64:0] act);
   checks++;
   if (act !== exp) begin
      $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
      test_errors++;
      errors++;
   end
endtask

task automatic report(input string msg);
   $display("ERROR %s: %s", cur_test, msg);
   test_errors++;
   errors++;
endtask

// ##################################################
// drivers, all entered at a falling edge
// ##################################################
task automatic reg_write(input int idx, input logic [31:0] val);
   mi_en   = 1'b1;
   mi_we   = 1'b1;
   mi_addr = 15'(idx * 4);  // byte address
   mi_din  = val;
   @(negedge clk);
   mi_en   = 1'b0;
   mi_we   = 1'b0;
endtask

task automatic reg_read(input int idx, output logic [31:0] val);
   mi_en   = 1'b1;
   mi_we   = 1'b0;
   mi_addr = 15'(idx * 4);
   @(negedge clk);
   mi_en   = 1'b0;
   val     = mi_dout;  // registered at the edge just passed
endtask

task automatic send_pkt(input erx_pkt_t p);
   int n;
   n        = 0;
   in_pkt   = p;
   in_valid = 1'b1;
   #1;  // ready follows out_ready through the pipe
   while (!in_ready && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
   end
   if (!in_ready) begin
      report("in_ready never rose, packet not taken");
   end
   @(negedge clk);  // transfer edge
   in_valid = 1'b0;
endtask

// takes everything in exp_q off the output, in order
task automatic drain(input string what);
   int n;
   n         = 0;
   out_ready = 1'b1;
   while (exp_q.size() > 0 && n < WAIT_MAX) begin
      if (out_valid) begin
         check(what, exp_q.pop_front(), out_pkt);
      end
      @(negedge clk);
      n++;
   end
   if (exp_q.size() > 0) begin
      report("expected packets never reached the output");
      exp_q.delete();
   end
endtask

// ##################################################
// directed tests
// ##################################################
task automatic test_regs();
   logic [31:0] cfg_val;
   logic [31:0] off_val;
   logic [31:0] rd;
   start_test("regs");
   check("mi_dout after reset", 65'd0, 65'(mi_dout));
   check("out_valid after reset", 65'd0, 65'(out_valid));
   cfg_val = rand_bits(32);
   off_val = rand_bits(32);
   reg_write(ERX_CFG, cfg_val);
   reg_write(ERX_OFFSET, off_val);
   reg_read(ERX_CFG, rd);
   check("cfg readback", 65'(cfg_val), 65'(rd));
   reg_read(ERX_OFFSET, rd);
   check("offset readback", 65'(off_val), 65'(rd));
   reg_read(37, rd);  // nothing mapped here
   check("unmapped word", 65'd0, 65'(rd));
   @(negedge clk);
   check("idle cycle", 65'd0, 65'(mi_dout));
   gpio_datain = 9'(rand_bits(9));
   @(negedge clk);  // pins sampled
   reg_read(ERX_GPIO, rd);
   check("gpio", 65'({23'b0, gpio_datain}), 65'(rd));
   reg_write(ERX_CFG, 32'h0);
   end_test();
endtask

task automatic test_idelay();
   logic [31:0] w0;
   logic [31:0] w1;
   start_test("idelay");
   w0 = rand_bits(32);
   w1 = rand_bits(32);
   reg_write(ERX_IDELAY0, w0);
   check("load_taps before", 65'd0, 65'(load_taps));
   reg_write(ERX_IDELAY1, w1);
   check("load_taps pulse", 65'd1, 65'(load_taps));
   check("idelay_value", 65'({w1[14:0], w0[29:0]}), 65'(idelay_value));
   @(negedge clk);
   check("load_taps after", 65'd0, 65'(load_taps));
   end_test();
endtask

task automatic test_remap();
   logic [11:0] sel;
   logic [11:0] pattern;
   logic [31:0] base;
   erx_pkt_t    p;
   erx_pkt_t    e;
   start_test("remap");
   out_ready = 1'b1;
   for (int mode = 0; mode < 3; mode++) begin  // none, static, dynamic
      sel     = 12'(rand_bits(12));
      pattern = 12'(rand_bits(12));
      base    = rand_bits(32);
      reg_write(ERX_OFFSET, base);
      reg_write(ERX_CFG, cfg_word(1'b1, 2'(mode), sel, pattern, 2'b00));
      p           = rand_pkt();
      e           = p;
      e.addr.flat = remapped(2'(mode), sel, pattern, base, p.addr.flat);
      exp_q.push_back(e);
      send_pkt(p);
      check("out_valid one cycle in", 65'd0, 65'(out_valid));
      @(negedge clk);
      check("out_valid two cycles in", 65'd1, 65'(out_valid));
      drain("remapped packet");
   end
   end_test();
endtask

task automatic test_backpressure();
   erx_pkt_t    p[3];
   logic [31:0] rd;
   start_test("backpressure");
   reg_write(ERX_CFG, cfg_word(1'b1, 2'b00, 12'h0, 12'h0, 2'b01));  // limit 16
   out_ready = 1'b0;
   for (int i = 0; i < 3; i++) begin
      p[i] = rand_pkt();
      exp_q.push_back(p[i]);
   end
   send_pkt(p[0]);
   send_pkt(p[1]);  // both stages now full
   in_pkt   = p[2];
   in_valid = 1'b1;
   repeat (8) @(negedge clk);  // well under the limit
   check("in_ready while full", 65'd0, 65'(in_ready));
   check("out_valid while held", 65'd1, 65'(out_valid));
   reg_read(ERX_STATUS, rd);  // busy, earlier deliveries stuck
   check("status while held", 65'h0c, 65'(rd[3:0]));
   out_ready = 1'b1;
   check("first packet", exp_q.pop_front(), out_pkt);
   send_pkt(p[2]);
   drain("queued packet");
   reg_read(ERX_STATUS, rd);
   check("status after drain", 65'h04, 65'(rd[3:0]));
   end_test();
endtask

task automatic test_timeout();
   erx_pkt_t    p;
   logic [31:0] rd;
   int          high;
   start_test("timeout");
   reg_write(ERX_CFG, cfg_word(1'b1, 2'b00, 12'h0, 12'h0, 2'b01));
   out_ready = 1'b0;
   p         = rand_pkt();
   send_pkt(p);
   high = 0;
   repeat (40) begin
      @(negedge clk);
      if (out_valid) begin
         high++;
      end
   end
   check("out_valid after stall", 65'd0, 65'(out_valid));
   check("held up to the limit", 65'd1, 65'(high >= 16));
   out_ready = 1'b1;
   repeat (4) begin
      @(negedge clk);
      if (out_valid) begin
         report("dropped packet showed up on the output");
      end
   end
   reg_read(ERX_STATUS, rd);
   check("timeout sticky bit", 65'd1, 65'(rd[0]));
   end_test();
endtask

task automatic test_disable();
   logic [31:0] rd;
   start_test("disable");
   reg_write(ERX_CFG, cfg_word(1'b0, 2'b00, 12'h0, 12'h0, 2'b00));  // rx off
   out_ready = 1'b1;
   send_pkt(rand_pkt());  // must still be consumed
   repeat (5) begin
      @(negedge clk);
      if (out_valid) begin
         report("packet came out while receive was disabled");
      end
   end
   reg_read(ERX_STATUS, rd);
   check("disabled drop bit", 65'd1, 65'(rd[1]));
   end_test();
endtask

//--- dv/erx_core_tb.sv
`timescale 1ns/1ns

module erx_core_tb;
   import erx_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int NUM_TESTS    = 6;
   localparam int LONGEST_TEST = 320;  // cycles, every handshake wait at its limit
   localparam int WAIT_MAX     = 50;   // cycles for one handshake

   // ################################################
   // DUT signals
   // ################################################
   logic        clk;
   logic        reset;
   logic        mi_en;
   logic        mi_we;
   logic [14:0] mi_addr;
   logic [31:0] mi_din;
   logic [31:0] mi_dout;
   logic [8:0]  gpio_datain;
   erx_pkt_t    in_pkt;
   logic        in_valid;
   logic        in_ready;
   erx_pkt_t    out_pkt;
   logic        out_valid;
   logic        out_ready;
   logic [44:0] idelay_value;
   logic        load_taps;

   // bookkeeping
   logic [31:0] lfsr = 32'd33;  // stimulus source
   string       cur_test;
   int          tests_run;
   int          checks;
   int          errors;
   int          test_errors;     // per test, for the summary line
   erx_pkt_t    exp_q[$];        // packets still owed by the output port

   erx_core #(
      .RFAW(6)
   ) DUT (.*);

   `include "erx_core_tasks.svh"

   // ################################################
   // clock and watchdog
   // ################################################
   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // worst case length of the whole sequence
   initial begin
      #(NUM_TESTS * LONGEST_TEST * CLK_PERIOD);
      $display("watchdog: the test sequence did not finish in time");
      $display("Done: errors found");
      $finish;
   end

   // ################################################
   // test sequence
   // ################################################
   initial begin
      reset       = 1'b1;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      mi_din      = '0;
      gpio_datain = '0;
      in_pkt      = '0;
      in_valid    = 1'b0;
      out_ready   = 1'b0;
      tests_run   = 0;
      checks      = 0;
      errors      = 0;
      repeat (3) @(posedge clk);  // 3 cycles in reset
      @(negedge clk);
      reset = 1'b0;

      test_regs();
      test_idelay();
      test_remap();
      test_backpressure();
      test_timeout();
      test_disable();

      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- erx_core.f
+incdir+dv
source/erx_pkg.sv
source/erx_cfg.sv
source/erx_remap.sv
source/erx_timeout.sv
source/erx_dispatch.sv
source/erx_core.sv
dv/erx_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the erx_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module erx_core_tb -f erx_core.f -o erx_core_sim \
   && ./obj_dir/erx_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "^Done: no errors$" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- source/erx_cfg.sv
`timescale 1ns/1ns

module erx_cfg #(
   parameter int RFAW = 6  // word address width
) (
   input  logic                 clk,
   input  logic                 reset,
   // simple memory interface
   input  logic                 mi_en,
   input  logic                 mi_we,        // whole 32 bit words only
   input  logic [14:0]          mi_addr,      // byte address
   input  logic [31:0]          mi_din,
   output logic [31:0]          mi_dout,
   // misc inputs
   input  logic [8:0]           gpio_datain,  // frame and data pins
   input  erx_pkg::erx_status_t status,       // pulses from dispatch
   // config outputs
   output erx_pkg::erx_rxcfg_t  rxcfg,
   output logic [31:0]          remap_base,   // dynamic remap base
   output logic [44:0]          idelay_value, // tap values for the idelay chain
   output logic                 load_taps     // one cycle after idelay1 write
);
   import erx_pkg::*;

   logic [RFAW-1:0] reg_idx;      // word index from byte address
   logic            cfg_write;
   logic            cfg_read;
   logic            rx_write;
   logic            offset_write;
   logic            idelay0_write;
   logic            idelay1_write;
   logic [31:0]     idelay0_reg;
   logic [31:0]     idelay1_reg;
   logic [8:0]      gpio_reg;
   logic [2:0]      sticky;       // {delivered, dis_drop, to_drop}

   // ################################################
   // decode
   // ################################################
   assign reg_idx   = mi_addr[RFAW+1:2];  // drop byte offset
   assign cfg_write = mi_en & mi_we;
   assign cfg_read  = mi_en & ~mi_we;

   assign rx_write      = cfg_write & (reg_idx == RFAW'(ERX_CFG));
   assign offset_write  = cfg_write & (reg_idx == RFAW'(ERX_OFFSET));
   assign idelay0_write = cfg_write & (reg_idx == RFAW'(ERX_IDELAY0));
   assign idelay1_write = cfg_write & (reg_idx == RFAW'(ERX_IDELAY1));

   // ################################################
   // config words
   // ################################################
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rxcfg <= '0;  // rx disabled, no remap, timer off
      end else if (rx_write) begin
         rxcfg <= erx_rxcfg_t'(mi_din);
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         remap_base <= '0;
      end else if (offset_write) begin
         remap_base <= mi_din;  // added to flat address
      end
   end

   // gpio pins sampled every cycle
   always_ff @(posedge clk) begin
      gpio_reg <= gpio_datain;
   end

   // events stick until hard reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         sticky <= '0;
      end else begin
         sticky <= sticky | {status.delivered, status.dis_drop, status.to_drop};
      end
   end

   // ################################################
   // idelay taps
   // ################################################
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         idelay0_reg <= '0;
         idelay1_reg <= '0;
         load_taps   <= 1'b0;
      end else begin
         if (idelay0_write) begin
            idelay0_reg <= mi_din;
         end
         if (idelay1_write) begin
            idelay1_reg <= mi_din;
         end
         load_taps <= idelay1_write;  // high word written last, then load
      end
   end

   // 15 bits from word 1 on top of 30 bits from word 0
   assign idelay_value = {idelay1_reg[14:0], idelay0_reg[29:0]};

   // ################################################
   // read back
   // ################################################

   // one cycle latency, zero when no read
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         mi_dout <= '0;
      end else if (cfg_read) begin
         case (reg_idx)
            RFAW'(ERX_CFG):     mi_dout <= rxcfg;
            RFAW'(ERX_OFFSET):  mi_dout <= remap_base;
            RFAW'(ERX_IDELAY0): mi_dout <= idelay0_reg;
            RFAW'(ERX_IDELAY1): mi_dout <= idelay1_reg;
            RFAW'(ERX_GPIO):    mi_dout <= {23'b0, gpio_reg};
            RFAW'(ERX_STATUS):  mi_dout <= {16'b0, status.zero, status.busy, sticky};
            default:            mi_dout <= '0;  // unmapped
         endcase
      end else begin
         mi_dout <= '0;
      end
   end

endmodule

//--- source/erx_core.sv
`timescale 1ns/1ns

module erx_core #(
   parameter int RFAW = 6  // register word address width
) (
   input  logic              clk,
   input  logic              reset,
   // register access
   input  logic              mi_en,
   input  logic              mi_we,
   input  logic [14:0]       mi_addr,
   input  logic [31:0]       mi_din,
   output logic [31:0]       mi_dout,
   input  logic [8:0]        gpio_datain,
   // packet in
   input  erx_pkg::erx_pkt_t in_pkt,
   input  logic              in_valid,
   output logic              in_ready,
   // packet out
   output erx_pkg::erx_pkt_t out_pkt,
   output logic              out_valid,
   input  logic              out_ready,
   // to the idelay chain
   output logic [44:0]       idelay_value,
   output logic              load_taps
);
   import erx_pkg::*;

   erx_rxcfg_t  rxcfg;       // live config word
   logic [31:0] remap_base;
   erx_status_t status;      // dispatch events
   erx_pkt_t    rm_pkt;      // remap -> dispatch
   logic        rm_valid;
   logic        rm_ready;
   logic        expire;      // stall timeout pulse

   // ################################################
   // register file
   // ################################################
   erx_cfg #(
      .RFAW(RFAW)
   ) u_cfg (
      .clk          (clk),
      .reset        (reset),
      .mi_en        (mi_en),
      .mi_we        (mi_we),
      .mi_addr      (mi_addr),
      .mi_din       (mi_din),
      .mi_dout      (mi_dout),
      .gpio_datain  (gpio_datain),
      .status       (status),
      .rxcfg        (rxcfg),
      .remap_base   (remap_base),
      .idelay_value (idelay_value),
      .load_taps    (load_taps)
   );

   // ################################################
   // packet path
   // ################################################
   erx_remap u_remap (
      .clk        (clk),
      .reset      (reset),
      .rxcfg      (rxcfg),
      .remap_base (remap_base),
      .in_pkt     (in_pkt),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .rm_pkt     (rm_pkt),
      .rm_valid   (rm_valid),
      .rm_ready   (rm_ready)
   );

   // watches the output handshake
   erx_timeout u_timeout (
      .clk       (clk),
      .reset     (reset),
      .timer_cfg (rxcfg.timer_cfg),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .expire    (expire)
   );

   erx_dispatch u_dispatch (
      .clk       (clk),
      .reset     (reset),
      .rx_enable (rxcfg.rx_enable),
      .rm_pkt    (rm_pkt),
      .rm_valid  (rm_valid),
      .rm_ready  (rm_ready),
      .expire    (expire),
      .out_pkt   (out_pkt),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .status    (status)
   );

endmodule

//--- source/erx_dispatch.sv
`timescale 1ns/1ns

module erx_dispatch (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 rx_enable,
   // from remap stage
   input  erx_pkg::erx_pkt_t    rm_pkt,
   input  logic                 rm_valid,
   output logic                 rm_ready,
   // from stall timer
   input  logic                 expire,
   // output port
   output erx_pkg::erx_pkt_t    out_pkt,
   output logic                 out_valid,
   input  logic                 out_ready,
   // event pulses to cfg
   output erx_pkg::erx_status_t status
);
   import erx_pkg::*;

   logic drain;   // output register empties this cycle
   logic accept;  // remap stage hands over a packet
   logic load;    // accepted and kept

   // ################################################
   // output register
   // ################################################

   // leaves by transfer or by timeout drop
   assign drain    = out_valid & (out_ready | expire);
   assign rm_ready = ~out_valid | drain;
   assign accept   = rm_valid & rm_ready;
   assign load     = accept & rx_enable;  // disabled -> swallow

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (rm_ready) begin
         out_valid <= rm_valid & rx_enable;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         out_pkt <= rm_pkt;
      end
   end

   // ################################################
   // events
   // ################################################

   // transfer wins over a same-cycle expire
   always_comb begin
      status           = '0;
      status.to_drop   = out_valid & expire & ~out_ready;
      status.dis_drop  = accept & ~rx_enable;
      status.delivered = out_valid & out_ready;
      status.busy      = out_valid;  // live, not sticky
   end

endmodule

//--- source/erx_pkg.sv
package erx_pkg;

   // ################################################
   // register map, word indices
   // ################################################
   localparam int unsigned ERX_CFG     = 0;  // rx config
   localparam int unsigned ERX_OFFSET  = 1;  // dynamic remap base
   localparam int unsigned ERX_IDELAY0 = 2;  // tap values, low word
   localparam int unsigned ERX_IDELAY1 = 3;  // tap values, high word
   localparam int unsigned ERX_GPIO    = 4;  // sampled gpio input
   localparam int unsigned ERX_STATUS  = 5;  // sticky events + busy

   // ################################################
   // packet address
   // ################################################

   // row/col view of a mesh address
   typedef struct packed {
      logic [5:0]  row;     // upper 6 bits
      logic [5:0]  col;     // next 6 bits
      logic [19:0] offset;  // local offset, untouched by remap
   } erx_addr_fields_t;

   // same word, two decodes
   // flat for base add, fields for static bit replace
   typedef union packed {
      logic [31:0]      flat;
      erx_addr_fields_t fields;
   } erx_addr_u;

   // 65 bit write packet
   typedef struct packed {
      erx_addr_u   addr;   // destination
      logic [31:0] data;
      logic        write;  // write flag, carried through
   } erx_pkt_t;

   // ################################################
   // config and status
   // ################################################
   typedef enum logic [1:0] {
      REMAP_NONE    = 2'b00,
      REMAP_STATIC  = 2'b01,
      REMAP_DYNAMIC = 2'b10,
      REMAP_NONE2   = 2'b11  // behaves as none
   } erx_remap_mode_e;

   // mirror of the ERX_CFG word, msb first
   typedef struct packed {
      logic [1:0]      reserved;       // 31:30, stored only
      logic [1:0]      timer_cfg;      // 29:28, 00 = off
      logic [11:0]     remap_pattern;  // 27:16
      logic [11:0]     remap_sel;      // 15:4
      erx_remap_mode_e remap_mode;     // 3:2
      logic            mmu_enable;     // 1, no mmu in this slice
      logic            rx_enable;      // 0
   } erx_rxcfg_t;

   // event pulses and busy, from the dispatch stage
   typedef struct packed {
      logic [11:0] zero;       // always zero
      logic        busy;       // output register full
      logic        delivered;  // packet left on the output port
      logic        dis_drop;   // discarded while rx disabled
      logic        to_drop;    // dropped on stall timeout
   } erx_status_t;

endpackage

//--- source/erx_remap.sv
`timescale 1ns/1ns

module erx_remap (
   input  logic                clk,
   input  logic                reset,
   input  erx_pkg::erx_rxcfg_t rxcfg,       // mode, sel, pattern
   input  logic [31:0]         remap_base,  // dynamic base
   // upstream
   input  erx_pkg::erx_pkt_t   in_pkt,
   input  logic                in_valid,
   output logic                in_ready,
   // to dispatch
   output erx_pkg::erx_pkt_t   rm_pkt,
   output logic                rm_valid,
   input  logic                rm_ready
);
   import erx_pkg::*;

   erx_pkt_t    mapped;    // packet with remapped address
   logic [11:0] rowcol;    // {row, col} of the incoming address
   logic [11:0] new_rc;    // after static replace
   logic        take;      // input transfer this cycle

   // ################################################
   // address remap
   // ################################################
   assign rowcol = {in_pkt.addr.fields.row, in_pkt.addr.fields.col};

   // sel bit set -> take pattern bit
   assign new_rc = (rowcol & ~rxcfg.remap_sel) | (rxcfg.remap_pattern & rxcfg.remap_sel);

   always_comb begin
      mapped = in_pkt;  // data and write flag unchanged
      case (rxcfg.remap_mode)
         REMAP_STATIC: begin
            mapped.addr.fields.row = new_rc[11:6];
            mapped.addr.fields.col = new_rc[5:0];
         end
         REMAP_DYNAMIC: begin
            mapped.addr.flat = in_pkt.addr.flat + remap_base;  // wraps at 32 bits
         end
         default: begin
            mapped = in_pkt;  // none, none2
         end
      endcase
   end

   // ################################################
   // pipeline register
   // ################################################
   assign in_ready = ~rm_valid | rm_ready;  // empty or draining
   assign take     = in_valid & in_ready;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rm_valid <= 1'b0;
      end else if (in_ready) begin
         rm_valid <= in_valid;  // refill or go empty
      end
   end

   // payload, no reset
   always_ff @(posedge clk) begin
      if (take) begin
         rm_pkt <= mapped;
      end
   end

endmodule

//--- source/erx_timeout.sv
`timescale 1ns/1ns

module erx_timeout (
   input  logic       clk,
   input  logic       reset,
   input  logic [1:0] timer_cfg,  // 00 off, 01/10/11 = 16/64/256
   input  logic       out_valid,
   input  logic       out_ready,
   output logic       expire      // one cycle pulse
);
   localparam int CW = 9;  // holds 256

   logic [CW-1:0] count;   // consecutive stalled cycles
   logic [CW-1:0] limit;
   logic          stall;

   // ################################################
   // limit decode
   // ################################################
   always_comb begin
      case (timer_cfg)
         2'b01:   limit = 9'd16;
         2'b10:   limit = 9'd64;
         2'b11:   limit = 9'd256;
         default: limit = 9'd0;  // timer off, never reached
      endcase
   end

   // held packet not taken, timer enabled
   assign stall = out_valid & ~out_ready & (timer_cfg != 2'b00);

   // ################################################
   // stall counter
   // ################################################
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         count  <= '0;
         expire <= 1'b0;
      end else if (stall) begin
         if (count == limit - 9'd1) begin
            count  <= '0;    // limit-th stalled cycle
            expire <= 1'b1;
         end else begin
            count  <= count + 9'd1;
            expire <= 1'b0;
         end
      end else begin
         // transfer or idle cycle restarts the count
         count  <= '0;
         expire <= 1'b0;
      end
   end

endmodule
